// ==== tb_input.txt ====
# P <program word hex> | E <name> <store addr hex> <data hex>
# A <name> <addr> any data | G <name> <addr> <min increase over previous, decimal>
P 20000513
P 06400093
P 00152023
P ff900113
P 002081b3
P 00352223
P 40208233
P 00452423
P 0020f2b3
P 00552623
P 0020e333
P 00652823
P 0020c3b3
P 00752a23
P 00300413
P 008094b3
P 00952c23
P 008155b3
P 00b52e23
P 00112633
P 02c52023
P abcde6b7
P 02d52223
P 00452703
P 02e52423
P 00508013
P 02052623
P 00108463
P 02152823
P 00109463
P 02152a23
P 00209463
P 02152c23
P 00208463
P 02152e23
P 008007ef
P 04152023
P 04f52223
P b00021f3
P 00108093
P 00108093
P b0002273
P 04352423
P 04452623
P 0000006f
E addi 200 00000064
E add 204 0000005d
E sub 208 0000006b
E and 20c 00000060
E or 210 fffffffd
E xor 214 ffffff9d
E sll 218 00000320
E srl 21c 1fffffff
E slt 220 00000001
E lui 224 abcde000
E lw_round_trip 228 0000005d
E store_x0 22c 00000000
E bne_not_taken 234 00000064
E beq_not_taken 23c 00000064
E jal_link 244 00000090
A mcycle_first 248
G mcycle_second 24c 9

// ==== files.f ====
+incdir+.
core_pkg.sv
inst_decode.sv
reg_file.sv
alu.sv
cycle_counter.sv
core_ctrl.sv
core_top.sv
tb_checker.sv
tb_core.sv

// ==== Makefile ====
# Verilator build and run for the rv32e-subset core
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD     ?= obj_dir
FLIST     ?= files.f
PASS_MSG  ?= Test completed successfully

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD)

// ==== tb_core.sv ====
/*
 * testbench top for the rv32e-subset core
 * loads program words and expected stores from tb_input.txt, models a
 * 1K-word wishbone memory with random wait states and guards the run
 */
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core;
    localparam int CLK_NS      = 4;
    localparam int RST_CYCLES  = 5;
    // cycle budget per program word
    localparam int CYC_PER_WORD = 20;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        done;
    int          err_cnt;
    int          pending;

    logic [31:0] mem [1024];
    int          n_prog;
    bit          loaded;
    bit          busy;
    int          wait_left;

    core_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    tb_checker u_check (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .done     (done),
        .err_cnt  (err_cnt),
        .pending  (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // P lines fill memory, E / A / G lines go to the checker
    task automatic load_input(output int words);
        int          fd;
        int          code;
        int          base;
        string       line;
        string       tag;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        words = 0;
        base  = `CORE_RESET_PC >> 2;
        fd    = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb_input.txt, no stimulus");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    code = $sscanf(line, "%s", tag);
                    if (tag == "P") begin
                        code = $sscanf(line, "%s %h", tag, d);
                        mem[base + words] = d;
                        words++;
                    end else if (tag == "E") begin
                        code = $sscanf(line, "%s %s %h %h", tag, name, a, d);
                        u_check.add_expect(name, 0, a, d);
                    end else if (tag == "A") begin
                        code = $sscanf(line, "%s %s %h", tag, name, a);
                        u_check.add_expect(name, 1, a, 32'd0);
                    end else if (tag == "G") begin
                        code = $sscanf(line, "%s %s %h %d", tag, name, a, d);
                        u_check.add_expect(name, 2, a, d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // memory slave, ack after 0..3 wait cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack = 1'b0;
            busy   = 1'b0;
        end else if (wb_ack) begin
            // master drops cyc on the ack edge
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0) begin
                busy   = 1'b0;
                wb_ack = 1'b1;
                if (wb_we) begin
                    mem[wb_adr[11:2]] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[wb_adr[11:2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    // hang guard, budget scales with program size
    initial begin
        wait (loaded);
        #(n_prog * CYC_PER_WORD * CLK_NS + RST_CYCLES * CLK_NS);
        $display("watchdog expired, core hung with %0d stores still pending", pending);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hd7ce356f));
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = 32'd0;
        busy     = 1'b0;
        wait_left = 0;
        // background pattern, unique per word
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'ha5a5_0000 | i;
        end
        load_input(n_prog);
        if (n_prog == 0) begin
            $display("no program words loaded, nothing to run");
            $display("Test failed");
        end else begin
            loaded = 1'b1;
            repeat (RST_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            wait (done);
            // room for a stray store after the list
            repeat (40) @(posedge clk);
            $display("errors %0d, missing stores %0d", err_cnt, pending);
            if (err_cnt == 0 && pending == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
/*
 * store checker for the core testbench
 * watches acked wishbone writes and compares them in order with the
 * expected records handed over by the loader through add_expect
 */
`timescale 1ns/1ps

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    input  logic        wb_ack,
    output logic        done,
    output int          err_cnt,
    output int          pending
);
    // kind 0 exact data, 1 any data, 2 at least previous plus dats
    string       names [$];
    int          kinds [$];
    logic [31:0] adrs  [$];
    logic [31:0] dats  [$];
    int          idx    = 0;
    int          n_err  = 0;
    int          n_pend = 0;
    logic [31:0] prev   = 32'd0;

    assign done    = (n_pend == 0);
    assign err_cnt = n_err;
    assign pending = n_pend;

    task automatic add_expect(string name, int kind, logic [31:0] adr, logic [31:0] dat);
        names.push_back(name);
        kinds.push_back(kind);
        adrs.push_back(adr);
        dats.push_back(dat);
        n_pend++;
    endtask

    task automatic check_store();
        logic [31:0] floor_v;
        floor_v = prev + dats[idx];
        if (wb_adr != adrs[idx]) begin
            $display("ERR %s address expected %h actual %h", names[idx], adrs[idx], wb_adr);
            n_err++;
        end
        if (kinds[idx] == 0 && wb_dat_w != dats[idx]) begin
            $display("ERR %s data expected %h actual %h", names[idx], dats[idx], wb_dat_w);
            n_err++;
        end
        // counter must move forward by at least the minimum
        if (kinds[idx] == 2 && (wb_dat_w <= prev || wb_dat_w < floor_v)) begin
            $display("ERR %s data expected >= %h actual %h", names[idx], floor_v, wb_dat_w);
            n_err++;
        end
        prev = wb_dat_w;
        idx++;
        n_pend--;
    endtask

    always @(posedge clk) begin
        if (rst_n && wb_cyc && wb_stb && wb_ack) begin
            // word access only, all byte lanes on every transfer
            if (wb_sel != 4'hf) begin
                $display("ERR wb_sel expected %h actual %h", 4'hf, wb_sel);
                n_err++;
            end
            if (wb_we) begin
                if (idx >= names.size()) begin
                    $display("unexpected store to %h with data %h after the expected list",
                             wb_adr, wb_dat_w);
                    n_err++;
                end else begin
                    check_store();
                end
            end
        end
    end

endmodule

// ==== core_top.sv ====
/*
 * rv32e-subset core top level
 * decoder, register file, alu, mcycle counter and controller
 * behind one wishbone classic master port
 */
`timescale 1ns/1ps

module core_top (
    input  logic            clk,
    input  logic            rst_n,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::word_t wb_adr,
    output core_pkg::word_t wb_dat_w,
    output logic [3:0]      wb_sel,
    input  core_pkg::word_t wb_dat_r,
    input  logic            wb_ack
);
    core_pkg::word_t     inst;
    core_pkg::word_t     pc;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::reg_addr_t rd;
    core_pkg::word_t     imm;
    core_pkg::opt_t      opt;
    logic [11:0]         csr_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    core_pkg::word_t     alu_result;
    logic                taken;
    core_pkg::word_t     csr_data;
    logic                rd_wen;
    core_pkg::word_t     rd_data;

    inst_decode u_decode (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .opt      (opt),
        .csr_addr (csr_addr)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (rd_wen),
        .waddr  (rd),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wdata  (rd_data),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    alu u_alu (
        .opt      (opt),
        .pc       (pc),
        .imm      (imm),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .taken    (taken)
    );

    // mcycle, the only readable csr
    cycle_counter u_mcycle (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_addr (csr_addr),
        .csr_data (csr_data)
    );

    core_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .inst       (inst),
        .pc         (pc),
        .opt        (opt),
        .rd         (rd),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .csr_data   (csr_data),
        .taken      (taken),
        .rd_wen     (rd_wen),
        .rd_data    (rd_data)
    );

endmodule

// ==== core_ctrl.sv ====
/*
 * multicycle controller
 * sequences fetch, decode, execute, mem and writeback for one instruction
 * at a time, owns the wishbone master, the pc and the instruction register
 */
`timescale 1ns/1ps
`include "core_params.svh"

module core_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output core_pkg::word_t     wb_adr,
    output core_pkg::word_t     wb_dat_w,
    output logic [3:0]          wb_sel,
    input  core_pkg::word_t     wb_dat_r,
    input  logic                wb_ack,
    output core_pkg::word_t     inst,
    output core_pkg::word_t     pc,
    input  core_pkg::opt_t      opt,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     alu_result,
    input  core_pkg::word_t     rs2_data,
    input  core_pkg::word_t     csr_data,
    input  logic                taken,
    output logic                rd_wen,
    output core_pkg::word_t     rd_data
);
    core_pkg::ctrl_state_t state;
    logic                  req;
    logic                  taken_q;
    logic                  mem_op;
    core_pkg::word_t       alu_q;
    core_pkg::word_t       load_q;
    core_pkg::word_t       store_q;
    core_pkg::word_t       pc_seq;

    assign mem_op = opt[`OPT_LOAD] | opt[`OPT_STORE];
    assign pc_seq = pc + 32'd4;

    // cyc and stb move together
    assign wb_cyc   = req;
    assign wb_stb   = req;
    assign wb_we    = (state == core_pkg::MEM) & opt[`OPT_STORE];
    // data address only during mem, pc otherwise
    assign wb_adr   = (state == core_pkg::MEM) ? alu_q : pc;
    assign wb_dat_w = store_q;
    assign wb_sel   = 4'hf;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= core_pkg::FETCH;
            req     <= 1'b0;
            taken_q <= 1'b0;
            pc      <= `CORE_RESET_PC;
            inst    <= `NOP_INST;
        end else begin
            case (state)
                core_pkg::FETCH: begin
                    // request is idle here only right after reset
                    if (!req) begin
                        req <= 1'b1;
                    end else if (wb_ack) begin
                        req   <= 1'b0;
                        inst  <= wb_dat_r;
                        state <= core_pkg::DECODE;
                    end
                end
                core_pkg::DECODE: state <= core_pkg::EXECUTE;
                core_pkg::EXECUTE: begin
                    taken_q <= taken;
                    if (mem_op) begin
                        // raise the data request on entry to mem
                        req   <= 1'b1;
                        state <= core_pkg::MEM;
                    end else begin
                        state <= core_pkg::WRITEBACK;
                    end
                end
                core_pkg::MEM: if (wb_ack) begin
                    req   <= 1'b0;
                    state <= core_pkg::WRITEBACK;
                end
                core_pkg::WRITEBACK: begin
                    // branch and jal targets come from the latched alu sum
                    pc    <= taken_q ? alu_q : pc_seq;
                    req   <= 1'b1;
                    state <= core_pkg::FETCH;
                end
                default: state <= core_pkg::FETCH;
            endcase
        end
    end

    // datapath latches
    always_ff @(posedge clk) begin
        if (state == core_pkg::EXECUTE) begin
            alu_q   <= alu_result;
            store_q <= rs2_data;
        end
        if (state == core_pkg::MEM && wb_ack && opt[`OPT_LOAD]) begin
            load_q <= wb_dat_r;
        end
    end

    assign rd_wen = (state == core_pkg::WRITEBACK) & opt[`OPT_WEN] & (rd != '0);

    // writeback source
    always_comb begin
        if (opt[`OPT_JUMP]) begin
            rd_data = pc_seq;
        end else if (opt[`OPT_LOAD]) begin
            rd_data = load_q;
        end else if (opt[`OPT_CSR]) begin
            rd_data = csr_data;
        end else begin
            rd_data = alu_q;
        end
    end

    // a request only ever stands in a bus phase
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> (wb_cyc && (state == core_pkg::FETCH || state == core_pkg::MEM)));

    // request held unchanged until the slave acks
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)));

endmodule

// ==== cycle_counter.sv ====
/*
 * free-running mcycle counter
 * counts every clock from reset, read through the csr address port
 */
`timescale 1ns/1ps
`include "core_params.svh"

module cycle_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [11:0]     csr_addr,
    output core_pkg::word_t csr_data
);
    core_pkg::word_t mcycle;

    // low 32 bits only, wraps silently
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle <= '0;
        end else begin
            mcycle <= mcycle + 32'd1;
        end
    end

    // only mcycle is mapped, other csrs read as zero
    assign csr_data = (csr_addr == `CSR_MCYCLE) ? mcycle : '0;

endmodule

// ==== alu.sv ====
/*
 * combinational alu
 * operand pair picked by the OPT_SRC field, function by the alu code
 * also flags a taken branch or a jump for the pc update
 */
`timescale 1ns/1ps
`include "core_params.svh"

module alu (
    input  core_pkg::opt_t  opt,
    input  core_pkg::word_t pc,
    input  core_pkg::word_t imm,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    output core_pkg::word_t result,
    output logic            taken
);
    core_pkg::word_t   op_a;
    core_pkg::word_t   op_b;
    core_pkg::word_t   sum;
    core_pkg::alu_op_t func;

    // operand select
    always_comb begin
        case (opt[`OPT_SRC_HI:`OPT_SRC_LO])
            `SRC_PC_4: begin
                // nop words land here
                op_a = pc;
                op_b = 32'd4;
            end
            `SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            `SRC_RS1_RS2: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            default: begin
                op_a = rs1_data;
                op_b = imm;
            end
        endcase
    end

    assign func = opt[`OPT_ALU_HI:`OPT_ALU_LO];
    assign sum  = opt[`OPT_SUB] ? (op_a - op_b) : (op_a + op_b);

    always_comb begin
        case (func)
            `ALU_AND:   result = op_a & op_b;
            `ALU_OR:    result = op_a | op_b;
            `ALU_XOR:   result = op_a ^ op_b;
            // shift amount is the low five bits
            `ALU_SLL:   result = op_a << op_b[4:0];
            `ALU_SRL:   result = op_a >> op_b[4:0];
            `ALU_SLT:   result = {31'd0, $signed(op_a) < $signed(op_b)};
            `ALU_PASSB: result = op_b;
            default:    result = sum;
        endcase
    end

    // bne inverts the equality test
    assign taken = opt[`OPT_JUMP]
                 | (opt[`OPT_BRANCH] & ((rs1_data == rs2_data) ^ opt[`OPT_BNE]));

endmodule

// ==== reg_file.sv ====
/*
 * 16 x 32 register file, two asynchronous read ports, one write port
 * writes to x0 are dropped, so x0 reads back as zero after reset
 */
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wen,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);
    core_pkg::word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // plain array reads, x0 kept zero by the write guard
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 must never pick up a value from any writeback
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((raddr1 == '0) |-> (rdata1 == '0)) and ((raddr2 == '0) |-> (rdata2 == '0)));

endmodule

// ==== inst_decode.sv ====
/*
 * combinational instruction decoder
 * splits the instruction register into register indices, immediate,
 * csr address and the operation word used by alu and controller
 * anything unsupported comes out as an all-zero word, i.e. a nop
 */
`timescale 1ns/1ps
`include "core_params.svh"

module inst_decode (
    input  core_pkg::word_t     inst,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     imm,
    output core_pkg::opt_t      opt,
    output logic [11:0]         csr_addr
);
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_s;
    core_pkg::word_t   imm_b;
    core_pkg::word_t   imm_j;
    core_pkg::word_t   imm_u;
    core_pkg::alu_op_t r_op;
    logic              r_ok;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // rv32e, low four bits of each register field
    assign rs1 = inst[18:15];
    assign rs2 = inst[23:20];
    assign rd  = inst[10:7];
    assign csr_addr = inst[31:20];

    // sign-extended immediates per format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // register-register function from funct3
    always_comb begin
        r_ok = (funct7 == 7'b0000000);
        r_op = `ALU_ADD;
        case (funct3)
            3'b000: begin
                // add, or sub with funct7 = 0x20
                r_op = `ALU_ADD;
                r_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            3'b001: r_op = `ALU_SLL;
            3'b010: r_op = `ALU_SLT;
            3'b100: r_op = `ALU_XOR;
            3'b101: r_op = `ALU_SRL;
            3'b110: r_op = `ALU_OR;
            3'b111: r_op = `ALU_AND;
            // sltu not supported
            default: r_ok = 1'b0;
        endcase
    end

    always_comb begin
        opt = '0;
        imm = '0;
        case (opcode)
            // addi only
            7'b0010011: if (funct3 == 3'b000) begin
                imm = imm_i;
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_RS1_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_ADD;
            end
            7'b0110011: if (r_ok) begin
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_RS1_RS2;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = r_op;
                opt[`OPT_SUB] = funct7[5];
            end
            // lui, upper immediate passed through as operand b
            7'b0110111: begin
                imm = imm_u;
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_PC_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_PASSB;
            end
            // lw, address rs1 + imm
            7'b0000011: if (funct3 == 3'b010) begin
                imm = imm_i;
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_LOAD] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_RS1_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_ADD;
            end
            // sw
            7'b0100011: if (funct3 == 3'b010) begin
                imm = imm_s;
                opt[`OPT_STORE] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_RS1_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_ADD;
            end
            // beq / bne, alu forms the target pc + imm
            7'b1100011: if (funct3[2:1] == 2'b00) begin
                imm = imm_b;
                opt[`OPT_BRANCH] = 1'b1;
                opt[`OPT_BNE] = funct3[0];
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_PC_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_ADD;
            end
            // jal, link value pc + 4 comes from the controller
            7'b1101111: begin
                imm = imm_j;
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_JUMP] = 1'b1;
                opt[`OPT_SRC_HI:`OPT_SRC_LO] = `SRC_PC_IMM;
                opt[`OPT_ALU_HI:`OPT_ALU_LO] = `ALU_ADD;
            end
            // csrrs rd, csr, x0 as a plain csr read
            7'b1110011: if (funct3 == 3'b010 && inst[19:15] == 5'd0) begin
                opt[`OPT_WEN] = 1'b1;
                opt[`OPT_CSR] = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== core_pkg.sv ====
/*
 * shared types for the multicycle rv32e core
 * every rtl file refers to these by scoped name, core_pkg::word_t etc
 * numeric constants and the operation word layout are in core_params.svh
 */
package core_pkg;

    // data, address and instruction values
    typedef logic [31:0] word_t;

    // rv32e register index, 16 registers
    typedef logic [3:0] reg_addr_t;

    // decoded operation word, see the bit map in core_params.svh
    typedef logic [15:0] opt_t;

    // alu function select, one of the ALU_* codes
    typedef logic [2:0] alu_op_t;

    // controller phases, one instruction in flight
    typedef enum logic [2:0] {
        // bus read of the instruction at pc
        FETCH,
        // register file read settles
        DECODE,
        // alu result and branch flag latched
        EXECUTE,
        // bus access for lw / sw only
        MEM,
        // rd write and pc update
        WRITEBACK
    } ctrl_state_t;

endpackage

// ==== core_params.svh ====
/*
 * core constants: reset vector, register count, operation word layout,
 * alu function codes, operand-select codes and csr addresses
 * include in any file that uses one of these macros
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch after reset
`define CORE_RESET_PC   32'h0000_0000
`define CORE_NUM_REGS   16
// addi x0, x0, 0
`define NOP_INST        32'h0000_0013
`define CSR_MCYCLE      12'hb00

// operation word bit positions
`define OPT_WEN         0
`define OPT_SRC_LO      3
`define OPT_SRC_HI      4
`define OPT_ALU_LO      5
`define OPT_ALU_HI      7
`define OPT_BRANCH      8
`define OPT_JUMP        9
`define OPT_LOAD        10
`define OPT_STORE       11
`define OPT_CSR         12
`define OPT_SUB         13
`define OPT_BNE         15

// operand pairs selected by the OPT_SRC field
`define SRC_PC_4        2'b00
`define SRC_PC_IMM      2'b01
`define SRC_RS1_RS2     2'b10
`define SRC_RS1_IMM     2'b11

// alu function codes
`define ALU_ADD         3'd0
`define ALU_AND         3'd1
`define ALU_OR          3'd2
`define ALU_XOR         3'd3
`define ALU_SLL         3'd4
`define ALU_SRL         3'd5
`define ALU_SLT         3'd6
`define ALU_PASSB       3'd7

`endif
